// ==== branch_jump_unit.sv ====
// branch condition decode and compare, jump kind select, link flag
`timescale 1ns/100ps

module branch_jump_unit import mips_decode_pkg::*; (
	input  logic [5:0]  i_opcode,
	input  logic [5:0]  i_funct,
	input  logic        i_rt_bit0,
	input  logic [31:0] i_rs_data,
	input  logic [31:0] i_rt_data,
	output logic        o_branch_taken,
	output jump_sel_e   o_jump_sel,
	output logic        o_link
);

	branch_op_e br_op;
	logic       is_jr;
	logic       is_jalr;

	assign is_jr   = (i_opcode == OP_RTYPE) && (i_funct == FN_JR);
	assign is_jalr = (i_opcode == OP_RTYPE) && (i_funct == FN_JALR);

	// branch kind, regimm picks ltz/gez from rt bit 16
	always_comb begin
		case (i_opcode)
			OP_BEQ:    br_op = BR_EQ;
			OP_BNE:    br_op = BR_NE;
			OP_BLEZ:   br_op = BR_LEZ;
			OP_BGTZ:   br_op = BR_GTZ;
			OP_REGIMM: br_op = i_rt_bit0 ? BR_GEZ : BR_LTZ;
			default:   br_op = BR_NONE;
		endcase
	end

	// ========================================================================
	// condition evaluation
	// ========================================================================
	always_comb begin
		case (br_op)
			BR_EQ:   o_branch_taken = (i_rs_data == i_rt_data);
			BR_NE:   o_branch_taken = (i_rs_data != i_rt_data);
			BR_LEZ:  o_branch_taken = ($signed(i_rs_data) <= 32'sd0);
			BR_GTZ:  o_branch_taken = ($signed(i_rs_data) >  32'sd0);
			BR_LTZ:  o_branch_taken = i_rs_data[31];
			BR_GEZ:  o_branch_taken = !i_rs_data[31];
			default: o_branch_taken = 1'b0;
		endcase
	end

	// jump kind
	always_comb begin
		if ((i_opcode == OP_J) || (i_opcode == OP_JAL))
			o_jump_sel = JMP_IMM;
		else if (is_jr || is_jalr)
			o_jump_sel = JMP_REG;
		else
			o_jump_sel = JMP_NONE;
	end

	assign o_link = (i_opcode == OP_JAL) || is_jalr;

endmodule

// ==== compile.f ====
mips_decode_pkg.sv
main_control.sv
branch_jump_unit.sv
register_bank.sv
target_gen.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

// ==== decode_stage.sv ====
// decode stage top: field slicing, sub-block wiring, id/ex pipeline register, redirect
`timescale 1ns/100ps

module decode_stage import mips_decode_pkg::*; (
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic [31:0] i_pc4,
	input  logic [31:0] i_instr,
	input  wb_write_t   i_wb,
	output id_ex_t      o_id_ex,
	output redirect_t   o_redirect
);

	// instruction fields
	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [4:0]  rd_addr;
	logic [15:0] imm;
	logic [25:0] index;

	ex_ctrl_t    ex_ctrl;
	mem_ctrl_t   mem_ctrl;
	wb_ctrl_t    wb_ctrl;
	logic        sign_ext;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic        branch_taken;
	jump_sel_e   jump_sel;
	logic        link;
	logic [31:0] imm_ext;
	logic [31:0] branch_target;
	logic [31:0] jump_target_imm;
	logic [31:0] jump_target_reg;
	id_ex_t      id_ex_d;
	id_ex_t      id_ex_q;

	assign opcode  = i_instr[31:26];
	assign rs_addr = i_instr[25:21];
	assign rt_addr = i_instr[20:16];
	assign imm     = i_instr[15:0];
	assign index   = i_instr[25:0];
	assign funct   = i_instr[5:0];

	// jal has no rd field, it links into r31
	assign rd_addr = (link && (jump_sel == JMP_IMM)) ? 5'd31 : i_instr[15:11];

	// ========================================================================
	// sub-blocks
	// ========================================================================
	main_control u_main_control (
		.i_opcode   (opcode),
		.i_funct    (funct),
		.o_ex       (ex_ctrl),
		.o_mem      (mem_ctrl),
		.o_wb       (wb_ctrl),
		.o_sign_ext (sign_ext)
	);

	branch_jump_unit u_branch_jump_unit (
		.i_opcode       (opcode),
		.i_funct        (funct),
		.i_rt_bit0      (i_instr[16]),
		.i_rs_data      (rs_data),
		.i_rt_data      (rt_data),
		.o_branch_taken (branch_taken),
		.o_jump_sel     (jump_sel),
		.o_link         (link)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_nrst    (i_nrst),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_wb      (i_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	target_gen u_target_gen (
		.i_imm             (imm),
		.i_sign_ext        (sign_ext),
		.i_index           (index),
		.i_pc4             (i_pc4),
		.i_rs_data         (rs_data),
		.o_imm_ext         (imm_ext),
		.o_branch_target   (branch_target),
		.o_jump_target_imm (jump_target_imm),
		.o_jump_target_reg (jump_target_reg)
	);

	// ========================================================================
	// id/ex pipeline register
	// ========================================================================
	always_comb begin
		id_ex_d              = '0;
		id_ex_d.ex           = ex_ctrl;
		id_ex_d.ex.alu_pc4   = link;
		id_ex_d.mem          = mem_ctrl;
		id_ex_d.wb           = wb_ctrl;
		id_ex_d.wb.reg_write = wb_ctrl.reg_write | link;
		id_ex_d.rs_data      = rs_data;
		id_ex_d.rt_data      = rt_data;
		id_ex_d.imm_ext      = imm_ext;
		id_ex_d.pc4          = i_pc4;
		id_ex_d.rs_addr      = rs_addr;
		id_ex_d.rt_addr      = rt_addr;
		id_ex_d.rd_addr      = rd_addr;
	end

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst)
			id_ex_q <= '0;
		else
			id_ex_q <= id_ex_d;
	end

	assign o_id_ex = id_ex_q;

	// redirect back to fetch, same cycle
	assign o_redirect.branch_taken  = branch_taken;
	assign o_redirect.jump_sel      = jump_sel;
	assign o_redirect.branch_target = branch_target;
	assign o_redirect.jump_target   = (jump_sel == JMP_REG) ? jump_target_reg : jump_target_imm;

endmodule

// ==== decode_stage_assert.sv ====
// concurrent checks on the id/ex register and the redirect, bound into decode_stage
`timescale 1ns/100ps

module decode_stage_assert import mips_decode_pkg::*; (
	input logic      i_clk,
	input logic      i_nrst,
	input id_ex_t    i_id_ex,
	input redirect_t i_redirect
);

	// a memory access is a load or a store, never both
	mem_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(i_id_ex.mem.mem_read && i_id_ex.mem.mem_write))
		else $error("id_ex has mem_read and mem_write both set");

	redirect_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(i_redirect.branch_taken && (i_redirect.jump_sel != JMP_NONE)))
		else $error("branch taken together with a jump");

	// first edge out of reset still sees the cleared register
	reset_no_write: assert property (@(posedge i_clk)
		$rose(i_nrst) |-> !i_id_ex.wb.reg_write)
		else $error("reg_write set in the first cycle after reset");

endmodule

bind decode_stage decode_stage_assert u_decode_stage_assert (
	.i_clk      (i_clk),
	.i_nrst     (i_nrst),
	.i_id_ex    (o_id_ex),
	.i_redirect (o_redirect)
);

// ==== decode_tests.txt ====
# W addr data: write a register through one write-back strobe
# I pc4 instr wb_en wb_addr wb_data taken jsel br_target j_target ex mem wb rs rt imm rd
W 01 00000005
W 02 fffffffb
W 03 00000005
W 1f 00400100
W 00 12345678
# r-type, register read-back and write-through bypass
I 00001004 00222020 0 00 00000000 0 0 00009084 00888080 2a 0 8 00000005 fffffffb 00002020 04
I 00001008 00032822 0 00 00000000 0 0 0000b090 000ca088 2a 0 8 00000000 00000005 00002822 05
I 0000100c 00e73024 1 07 a5a5a5a5 0 0 0000d09c 039cc090 2a 0 8 a5a5a5a5 a5a5a5a5 00003024 06
I 00001010 00e14025 0 00 00000000 0 0 000110a4 03850094 2a 0 8 a5a5a5a5 00000005 00004025 08
I 00001014 0041482a 0 00 00000000 0 0 000130bc 010520a8 2a 0 8 fffffffb 00000005 0000482a 09
# immediates, loads and store
I 00001018 204afffc 0 00 00000000 0 0 00001008 012bfff0 04 0 8 fffffffb 00000000 fffffffc 1f
I 0000101c 282b8000 0 00 00000000 0 0 fffe101c 00ae0000 24 0 8 00000005 00000000 ffff8000 10
I 00001020 304c8001 0 00 00000000 0 0 fffe1024 01320004 14 0 8 fffffffb 00000000 00008001 10
I 00001024 342df0f0 0 00 00000000 0 0 ffffd3e4 00b7c3c0 1c 0 8 00000005 00000000 0000f0f0 1e
I 00001028 8c2e0008 0 00 00000000 0 0 00001048 00b80020 04 2 c 00000005 00000000 00000008 00
I 0000102c 804fffff 0 00 00000000 0 0 00001028 013ffffc 04 2 d fffffffb 00000000 ffffffff 1f
I 00001030 90707fff 0 00 00000000 0 0 0002102c 01c1fffc 04 2 e 00000005 00000000 00007fff 0f
I 00001034 ac220004 0 00 00000000 0 0 00001044 00880010 04 1 0 00000005 fffffffb 00000004 00
# branches, each condition taken then not taken
I 00002004 10230003 0 00 00000000 1 0 00002010 008c000c 00 0 0 00000005 00000005 00000003 00
I 00002008 1022fffe 0 00 00000000 0 0 00002000 008bfff8 00 0 0 00000005 fffffffb fffffffe 1f
I 0000200c 14220001 0 00 00000000 1 0 00002010 00880004 00 0 0 00000005 fffffffb 00000001 00
I 00002010 14230010 0 00 00000000 0 0 00002050 008c0040 00 0 0 00000005 00000005 00000010 00
I 00002014 18400020 0 00 00000000 1 0 00002094 01000080 00 0 0 fffffffb 00000000 00000020 00
I 00002018 18200020 0 00 00000000 0 0 00002098 00800080 00 0 0 00000005 00000000 00000020 00
I 0000201c 1c200008 0 00 00000000 1 0 0000203c 00800020 00 0 0 00000005 00000000 00000008 00
I 00002020 1c400008 0 00 00000000 0 0 00002040 01000020 00 0 0 fffffffb 00000000 00000008 00
I 00002024 04400004 0 00 00000000 1 0 00002034 01000010 00 0 0 fffffffb 00000000 00000004 00
I 00002028 04200004 0 00 00000000 0 0 00002038 00800010 00 0 0 00000005 00000000 00000004 00
I 0000202c 04010004 0 00 00000000 1 0 0000203c 00040010 00 0 0 00000000 00000005 00000004 00
I 00002030 04410004 0 00 00000000 0 0 00002040 01040010 00 0 0 fffffffb 00000005 00000004 00
# jumps and links
I 30000004 08100040 0 00 00000000 0 1 30000104 30400100 00 0 0 00000000 00000000 00000040 00
I 40000008 0c000100 0 00 00000000 0 1 40000408 40000400 03 0 8 00000000 00000000 00000100 1f
I 00003004 03e00008 0 00 00000000 0 2 00003024 00400100 2a 0 0 00400100 00000000 00000008 00
I 00003008 0020f009 0 00 00000000 0 2 fffff02c 00000005 2b 0 8 00000005 00000000 0000f009 1e

// ==== main_control.sv ====
// main control decoder: execute, memory and write-back control plus extension mode
`timescale 1ns/100ps

module main_control import mips_decode_pkg::*; (
	input  logic [5:0] i_opcode,
	input  logic [5:0] i_funct,
	output ex_ctrl_t   o_ex,
	output mem_ctrl_t  o_mem,
	output wb_ctrl_t   o_wb,
	output logic       o_sign_ext
);

	always_comb begin
		// unknown opcodes fall through with everything off
		o_ex       = '0;
		o_mem      = '0;
		o_wb       = '0;
		o_sign_ext = 1'b0;

		case (i_opcode)
			OP_RTYPE: begin
				o_ex.alu_op     = ALU_FUNCT;
				o_ex.reg_dst_rd = 1'b1;
				// jr only redirects, jalr writes its link into rd
				o_wb.reg_write  = (i_funct != FN_JR);
			end
			OP_ADDI, OP_SLTI: begin
				o_ex.alu_op      = (i_opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
				o_ex.alu_src_imm = 1'b1;
				o_wb.reg_write   = 1'b1;
				o_sign_ext       = 1'b1;
			end
			OP_ANDI, OP_ORI: begin
				o_ex.alu_op      = (i_opcode == OP_ORI) ? ALU_OR : ALU_AND;
				o_ex.alu_src_imm = 1'b1;
				o_wb.reg_write   = 1'b1;
			end
			OP_LW, OP_LB, OP_LBU: begin
				o_ex.alu_op      = ALU_ADD;
				o_ex.alu_src_imm = 1'b1;
				o_mem.mem_read   = 1'b1;
				o_wb.reg_write   = 1'b1;
				o_wb.mem_to_reg  = 1'b1;
				o_wb.load_sel    = (i_opcode == OP_LB)  ? LD_BYTE :
				                   (i_opcode == OP_LBU) ? LD_UBYTE : LD_WORD;
				o_sign_ext       = 1'b1;
			end
			OP_SW: begin
				o_ex.alu_op      = ALU_ADD;
				o_ex.alu_src_imm = 1'b1;
				o_mem.mem_write  = 1'b1;
				o_sign_ext       = 1'b1;
			end
			// branch offsets are signed
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM: begin
				o_sign_ext = 1'b1;
			end
			OP_JAL: begin
				// destination is forced to r31 at the stage top
				o_ex.reg_dst_rd = 1'b1;
				o_wb.reg_write  = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== mips_decode_pkg.sv ====
// opcode and function codes, control enums, decode stage structs
package mips_decode_pkg;

	// ========================================================================
	// instruction encodings
	// ========================================================================
	localparam logic [5:0] OP_RTYPE  = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;
	localparam logic [5:0] OP_J      = 6'h02;
	localparam logic [5:0] OP_JAL    = 6'h03;
	localparam logic [5:0] OP_BEQ    = 6'h04;
	localparam logic [5:0] OP_BNE    = 6'h05;
	localparam logic [5:0] OP_BLEZ   = 6'h06;
	localparam logic [5:0] OP_BGTZ   = 6'h07;
	localparam logic [5:0] OP_ADDI   = 6'h08;
	localparam logic [5:0] OP_SLTI   = 6'h0a;
	localparam logic [5:0] OP_ANDI   = 6'h0c;
	localparam logic [5:0] OP_ORI    = 6'h0d;
	localparam logic [5:0] OP_LB     = 6'h20;
	localparam logic [5:0] OP_LW     = 6'h23;
	localparam logic [5:0] OP_LBU    = 6'h24;
	localparam logic [5:0] OP_SW     = 6'h2b;

	// r-type function field
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	localparam int REG_COUNT = 32;

	// ========================================================================
	// control encodings
	// ========================================================================
	// ALU_FUNCT defers the choice to execute, which reads the function field
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_SLT   = 4'd4,
		ALU_FUNCT = 4'd5
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6
	} branch_op_e;

	typedef enum logic [1:0] {
		JMP_NONE = 2'd0,
		JMP_IMM  = 2'd1,
		JMP_REG  = 2'd2
	} jump_sel_e;

	typedef enum logic [1:0] {
		LD_WORD  = 2'd0,
		LD_BYTE  = 2'd1,
		LD_UBYTE = 2'd2
	} load_sel_e;

	// ========================================================================
	// stage bundles
	// ========================================================================
	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		logic    alu_pc4;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		load_sel_e load_sel;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t    ex;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
		logic [31:0] rs_data;
		logic [31:0] rt_data;
		logic [31:0] imm_ext;
		logic [31:0] pc4;
		logic [4:0]  rs_addr;
		logic [4:0]  rt_addr;
		logic [4:0]  rd_addr;
	} id_ex_t;

	typedef struct packed {
		logic        en;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_write_t;

	typedef struct packed {
		logic        branch_taken;
		jump_sel_e   jump_sel;
		logic [31:0] branch_target;
		logic [31:0] jump_target;
	} redirect_t;

endpackage

// ==== register_bank.sv ====
// 32x32 register file, two read ports, one write port, write-through bypass
`timescale 1ns/100ps

module register_bank import mips_decode_pkg::*; (
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic [4:0]  i_rs_addr,
	input  logic [4:0]  i_rt_addr,
	input  wb_write_t   i_wb,
	output logic [31:0] o_rs_data,
	output logic [31:0] o_rt_data
);

	logic [REG_COUNT-1:0][31:0] regs;
	logic                       wr_valid;

	// r0 is never written
	assign wr_valid = i_wb.en && (i_wb.addr != 5'd0);

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			regs <= '0;
		end else if (wr_valid) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// ========================================================================
	// read ports
	// ========================================================================
	// a write in flight is returned directly so decode sees it this cycle
	always_comb begin
		if (i_rs_addr == 5'd0)
			o_rs_data = '0;
		else if (wr_valid && (i_wb.addr == i_rs_addr))
			o_rs_data = i_wb.data;
		else
			o_rs_data = regs[i_rs_addr];

		if (i_rt_addr == 5'd0)
			o_rt_data = '0;
		else if (wr_valid && (i_wb.addr == i_rt_addr))
			o_rt_data = i_wb.data;
		else
			o_rt_data = regs[i_rt_addr];
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_decode_stage -f compile.f -o sim_decode || exit 1
out=$(./obj_dir/sim_decode)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && exit 0 || exit 1

// ==== target_gen.sv ====
// immediate extension, branch target adder, jump target forming
`timescale 1ns/100ps

module target_gen (
	input  logic [15:0] i_imm,
	input  logic        i_sign_ext,
	input  logic [25:0] i_index,
	input  logic [31:0] i_pc4,
	input  logic [31:0] i_rs_data,
	output logic [31:0] o_imm_ext,
	output logic [31:0] o_branch_target,
	output logic [31:0] o_jump_target_imm,
	output logic [31:0] o_jump_target_reg
);

	logic [31:0] imm_sext;
	logic [31:0] offset;

	assign imm_sext = {{16{i_imm[15]}}, i_imm};

	// andi/ori take the zero-extended form
	assign o_imm_ext = i_sign_ext ? imm_sext : {16'h0000, i_imm};

	// word offset, always signed
	assign offset          = {imm_sext[29:0], 2'b00};
	assign o_branch_target = i_pc4 + offset;

	// region of pc+4 with the 26-bit word index
	assign o_jump_target_imm = {i_pc4[31:28], i_index, 2'b00};
	assign o_jump_target_reg = i_rs_data;

endmodule

// ==== tb_decode_stage.sv ====
// testbench for the decode stage: tests file reader, stimulus driver, typed result checks
`timescale 1ns/100ps

module tb_decode_stage import mips_decode_pkg::*; ();

	localparam int RESET_TIMEOUT = 20;
	localparam int MAX_STEPS     = 2000;
	// ascii codes that start a line of the tests file
	localparam int CH_HASH = 35;
	localparam int CH_I    = 73;
	localparam int CH_W    = 87;
	localparam int CH_LF   = 10;

	logic        i_clk;
	logic        i_nrst;
	logic [31:0] i_pc4;
	logic [31:0] i_instr;
	wb_write_t   i_wb;
	id_ex_t      o_id_ex;
	redirect_t   o_redirect;

	int err_count;
	int test_count;
	int fail_count;
	bit aborted;

	// fields of one tests file line
	logic        f_wb_en;
	logic [4:0]  f_wb_addr;
	logic [31:0] f_pc4;
	logic [31:0] f_instr;
	logic [31:0] f_wb_data;
	logic        f_taken;
	logic [1:0]  f_jsel;
	logic [31:0] f_br_tgt;
	logic [31:0] f_j_tgt;
	logic [6:0]  f_ex;
	logic [1:0]  f_mem;
	logic [3:0]  f_wb;
	logic [31:0] f_rs;
	logic [31:0] f_rt;
	logic [31:0] f_imm;
	logic [4:0]  f_rd;

	decode_stage u_decode_stage (
		.i_clk      (i_clk),
		.i_nrst     (i_nrst),
		.i_pc4      (i_pc4),
		.i_instr    (i_instr),
		.i_wb       (i_wb),
		.o_id_ex    (o_id_ex),
		.o_redirect (o_redirect)
	);

	always #5 i_clk = ~i_clk;

	initial begin
		i_clk  = 1'b0;
		i_nrst = 1'b0;
		repeat (2) @(posedge i_clk);
		#1 i_nrst = 1'b1;
	end

	// ========================================================================
	// checks and drivers
	// ========================================================================
	task automatic check_redirect(input redirect_t expected);
		if (o_redirect !== expected) begin
			$display("** Error at %0t: redirect got %h, expected %h",
				$time, o_redirect, expected);
			err_count++;
		end
	endtask

	task automatic check_id_ex(input id_ex_t expected);
		if (o_id_ex !== expected) begin
			$display("** Error at %0t: id_ex got %h, expected %h",
				$time, o_id_ex, expected);
			err_count++;
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		i_instr    = '0;
		i_wb.en    = 1'b1;
		i_wb.addr  = addr;
		i_wb.data  = data;
		@(posedge i_clk);
		#1;
		i_wb.en = 1'b0;
	endtask

	// redirect checked mid-cycle, id_ex just after the capturing edge
	task automatic decode_one(input logic [31:0] pc4, input logic [31:0] instr,
		input wb_write_t wb, input redirect_t exp_rd, input id_ex_t exp_id);
		i_pc4   = pc4;
		i_instr = instr;
		i_wb    = wb;
		#4;
		check_redirect(exp_rd);
		@(posedge i_clk);
		#1;
		i_wb.en = 1'b0;
		check_id_ex(exp_id);
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		int        fd;
		int        c;
		int        n;
		int        k;
		int        steps;
		int        cycles;
		int        errs_before;
		bit        done;
		wb_write_t wb_in;
		redirect_t exp_rd;
		id_ex_t    exp_id;

		i_pc4      = '0;
		i_instr    = '0;
		i_wb       = '0;
		err_count  = 0;
		test_count = 0;
		fail_count = 0;
		aborted    = 1'b0;

		cycles = 0;
		while (i_nrst !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(negedge i_clk);
			cycles++;
		end
		if (i_nrst !== 1'b1) begin
			$display("timeout waiting for reset release");
			aborted = 1'b1;
		end else begin
			// nothing clocked in yet, so the pipeline register is still clear
			test_count++;
			errs_before = err_count;
			check_id_ex('0);
			if (err_count == errs_before) begin
				$display("test %0d: reset ok", test_count);
			end else begin
				$display("test %0d: reset mismatch", test_count);
				fail_count++;
			end
			@(posedge i_clk);
			#1;
		end

		fd = 0;
		if (!aborted) begin
			fd = $fopen("decode_tests.txt", "r");
			if (fd == 0) begin
				$display("could not open decode_tests.txt");
				aborted = 1'b1;
			end
		end

		done  = 1'b0;
		steps = 0;
		while (!aborted && !done && steps < MAX_STEPS) begin
			steps++;
			c = $fgetc(fd);
			if (c == -1) begin
				done = 1'b1;
			end else if (c == CH_HASH) begin
				k = 0;
				while (c != CH_LF && c != -1 && k < 256) begin
					c = $fgetc(fd);
					k++;
				end
			end else if (c == CH_W) begin
				n = $fscanf(fd, "%h %h", f_wb_addr, f_wb_data);
				if (n != 2) begin
					$display("malformed write line in decode_tests.txt");
					aborted = 1'b1;
				end else begin
					write_reg(f_wb_addr, f_wb_data);
				end
			end else if (c == CH_I) begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f_pc4, f_instr, f_wb_en, f_wb_addr, f_wb_data,
					f_taken, f_jsel, f_br_tgt, f_j_tgt,
					f_ex, f_mem, f_wb, f_rs, f_rt, f_imm, f_rd);
				if (n != 16) begin
					$display("malformed instruction line in decode_tests.txt");
					aborted = 1'b1;
				end else begin
					wb_in.en             = f_wb_en;
					wb_in.addr           = f_wb_addr;
					wb_in.data           = f_wb_data;
					exp_rd.branch_taken  = f_taken;
					exp_rd.jump_sel      = jump_sel_e'(f_jsel);
					exp_rd.branch_target = f_br_tgt;
					exp_rd.jump_target   = f_j_tgt;
					exp_id.ex            = ex_ctrl_t'(f_ex);
					exp_id.mem           = mem_ctrl_t'(f_mem);
					exp_id.wb            = wb_ctrl_t'(f_wb);
					exp_id.rs_data       = f_rs;
					exp_id.rt_data       = f_rt;
					exp_id.imm_ext       = f_imm;
					// pc4 and both source fields pass straight through
					exp_id.pc4           = f_pc4;
					exp_id.rs_addr       = f_instr[25:21];
					exp_id.rt_addr       = f_instr[20:16];
					exp_id.rd_addr       = f_rd;
					test_count++;
					errs_before = err_count;
					decode_one(f_pc4, f_instr, wb_in, exp_rd, exp_id);
					if (err_count == errs_before) begin
						$display("test %0d: instr %h ok", test_count, f_instr);
					end else begin
						$display("test %0d: instr %h mismatch", test_count, f_instr);
						fail_count++;
					end
				end
			end
		end
		if (!aborted && !done) begin
			$display("timeout waiting for end of decode_tests.txt");
			aborted = 1'b1;
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d, passed %0d, failed %0d",
			test_count, test_count - fail_count, fail_count);
		if (!aborted && fail_count == 0 && test_count > 1)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
